/* all.f */
+incdir+include
hw/wb_pkg.sv
hw/wb_pc_track.sv
hw/wb_load_unit.sv
hw/wb_csr_unit.sv
hw/wb_cf_unit.sv
hw/wb_gpr_arbiter.sv
hw/frv_writeback.sv
testbench/tb_writeback.sv

/* include/tb_vectors.svh */
// --------------------------------------------------------------------------
// Stimulus and expected values for the writeback testbench
// Rows run back to back, so each row's PC follows the one before it
// mtvec is 32'h8000_0100, mepc is 32'h8000_0040, interrupt cause is 7
// --------------------------------------------------------------------------
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Column order is name, fu, uop, rd, opr_a, opr_b, size, rdata, bus error,
//   csr error, irq, exp wen, exp wdata, exp cf, exp target, exp {cpu,intr},
//   exp cause and exp next pc
localparam int num_rows = 17;

task automatic fill_table();
    add_row("alu_add", 5'h01, 5'h00, 5'd5, 32'h1234_5678, 32'h0, 2'd2, 32'h0, 0, 0, 0,
            1, 32'h1234_5678, 0, 32'h0, 2'b00, 6'd0, 32'h8000_0004);
    add_row("mul_c", 5'h02, 5'h00, 5'd6, 32'hdead_beef, 32'h0, 2'd1, 32'h0, 0, 0, 0,
            1, 32'hdead_beef, 0, 32'h0, 2'b00, 6'd0, 32'h8000_0006);
    add_row("lb_off3", 5'h04, 5'b01011, 5'd7, 32'h8, 32'h1003, 2'd2, 32'h8033_2211,
            0, 0, 0, 1, 32'hffff_ff80, 0, 32'h0, 2'b00, 6'd0, 32'h8000_000a);
    add_row("lbu_off1", 5'h04, 5'b01010, 5'd8, 32'h2, 32'h1001, 2'd2, 32'h4433_f211,
            0, 0, 0, 1, 32'h0000_00f2, 0, 32'h0, 2'b00, 6'd0, 32'h8000_000e);
    add_row("lh_off2", 5'h04, 5'b01101, 5'd9, 32'hc, 32'h1002, 2'd2, 32'h9abc_1234,
            0, 0, 0, 1, 32'hffff_9abc, 0, 32'h0, 2'b00, 6'd0, 32'h8000_0012);
    add_row("lhu_off0", 5'h04, 5'b01100, 5'd10, 32'h3, 32'h2000, 2'd2, 32'h9abc_8765,
            0, 0, 0, 1, 32'h0000_8765, 0, 32'h0, 2'b00, 6'd0, 32'h8000_0016);
    add_row("lw", 5'h04, 5'b01110, 5'd11, 32'hf, 32'h2004, 2'd2, 32'hcafe_f00d,
            0, 0, 0, 1, 32'hcafe_f00d, 0, 32'h0, 2'b00, 6'd0, 32'h8000_001a);
    add_row("lw_buserr", 5'h04, 5'b01110, 5'd12, 32'hf, 32'h3000, 2'd2, 32'h5555_5555,
            1, 0, 0, 0, 32'h0, 1, 32'h8000_0100, 2'b10, 6'd5, 32'h8000_0100);
    add_row("jal", 5'h08, 5'd2, 5'd1, 32'h8000_0200, 32'h0, 2'd2, 32'h0, 0, 0, 0,
            1, 32'h8000_0104, 1, 32'h8000_0200, 2'b00, 6'd1, 32'h8000_0200);
    add_row("jalr", 5'h08, 5'd3, 5'd1, 32'h8000_0300, 32'h0, 2'd2, 32'h0, 0, 0, 0,
            1, 32'h8000_0204, 1, 32'h8000_0300, 2'b00, 6'd1, 32'h8000_0300);
    add_row("mret", 5'h08, 5'd6, 5'd0, 32'h0, 32'h0, 2'd2, 32'h0, 0, 0, 0,
            0, 32'h0, 1, 32'h8000_0040, 2'b00, 6'd0, 32'h8000_0040);
    add_row("csrr", 5'h10, 5'b10000, 5'd13, 32'h0, 32'h300, 2'd2, 32'h0, 0, 0, 0,
            1, 32'h0000_1800, 0, 32'h0, 2'b00, 6'd0, 32'h8000_0044);
    add_row("csrw_err", 5'h10, 5'b01000, 5'd0, 32'h5, 32'hf11, 2'd2, 32'h0, 0, 1, 0,
            0, 32'h0, 1, 32'h8000_0100, 2'b10, 6'd2, 32'h8000_0100);
    add_row("alu_irq", 5'h01, 5'h00, 5'd14, 32'h1111, 32'h0, 2'd2, 32'h0, 0, 0, 1,
            0, 32'h0, 1, 32'h8000_011c, 2'b01, 6'd7, 32'h8000_011c);
    add_row("ecall", 5'h08, 5'd5, 5'd0, 32'h0, 32'h0, 2'd2, 32'h0, 0, 0, 0,
            0, 32'h0, 1, 32'h8000_0100, 2'b10, 6'd11, 32'h8000_0100);
    add_row("ebreak", 5'h08, 5'd4, 5'd0, 32'h0, 32'h0, 2'd2, 32'h0, 0, 0, 0,
            0, 32'h0, 1, 32'h8000_0100, 2'b10, 6'd3, 32'h8000_0100);
    add_row("alu_last", 5'h01, 5'h00, 5'd15, 32'h0000_abcd, 32'h0, 2'd2, 32'h0, 0, 0, 0,
            1, 32'h0000_abcd, 0, 32'h0, 2'b00, 6'd0, 32'h8000_0104);
endtask

`endif

/* testbench/tb_writeback.sv */
// --------------------------------------------------------------------------
// Testbench for the writeback stage, table driven
// One instruction per row, held until the stage progresses
// Memory answers after 0 to 3 random cycles
// cf_ack follows cf_req by one cycle
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_writeback import wb_pkg::*; ();

    logic            g_clk;
    logic            g_resetn;
    wb_instr_t       s4;
    logic            s4_valid;
    logic            s4_busy;
    fwd_t            fwd;
    gpr_wr_t         gpr;
    logic            int_trap_req;
    trap_t           trap;
    logic            exec_mret;
    trace_t          trace;
    csr_req_t        csr;
    logic            csr_error;
    logic            cf_req;
    logic [31:0]     cf_target;
    logic            cf_ack;
    logic            hold_lsu_req;
    dmem_rsp_t       dmem;
    logic            dmem_ack;

    // Table columns
    string       row_name [0:31];
    logic [4:0]  row_fu [0:31];
    logic [4:0]  row_uop [0:31];
    logic [4:0]  row_rd [0:31];
    logic [31:0] row_opr_a [0:31];
    logic [31:0] row_opr_b [0:31];
    logic [1:0]  row_size [0:31];
    logic [31:0] row_rdata [0:31];
    logic        row_derr [0:31];
    logic        row_csr_err [0:31];
    logic        row_irq [0:31];
    logic        row_wen [0:31];
    logic [31:0] row_wdata [0:31];
    logic        row_cf [0:31];
    logic [31:0] row_target [0:31];
    logic [1:0]  row_kind [0:31];
    logic [5:0]  row_cause [0:31];
    logic [31:0] row_next [0:31];
    int          row_count;

    int checks;
    int errors;

    frv_writeback i_frv_writeback (
        .g_clk(g_clk), .g_resetn(g_resetn), .s4(s4), .s4_valid(s4_valid),
        .s4_busy(s4_busy), .fwd(fwd), .gpr(gpr), .int_trap_req(int_trap_req),
        .int_trap_cause(6'd7), .trap(trap), .exec_mret(exec_mret),
        .csr_mepc(32'h8000_0040), .csr_mtvec(32'h8000_0100), .vector_intrs(1'b1),
        .trace(trace), .csr(csr), .csr_rdata(32'h0000_1800), .csr_error(csr_error),
        .cf_req(cf_req), .cf_target(cf_target), .cf_ack(cf_ack),
        .hold_lsu_req(hold_lsu_req), .dmem(dmem), .dmem_ack(dmem_ack)
    );

    always #10 g_clk = !g_clk;    // 20 ns period

    task automatic add_row(string name, logic [4:0] fu, logic [4:0] uop, logic [4:0] rd,
                           logic [31:0] opr_a, logic [31:0] opr_b, logic [1:0] size,
                           logic [31:0] rdata, logic derr, logic csr_err, logic irq,
                           logic wen, logic [31:0] wdata, logic cf, logic [31:0] target,
                           logic [1:0] kind, logic [5:0] cause, logic [31:0] next_pc);
        row_name[row_count]    = name;
        row_fu[row_count]      = fu;
        row_uop[row_count]     = uop;
        row_rd[row_count]      = rd;
        row_opr_a[row_count]   = opr_a;
        row_opr_b[row_count]   = opr_b;
        row_size[row_count]    = size;
        row_rdata[row_count]   = rdata;
        row_derr[row_count]    = derr;
        row_csr_err[row_count] = csr_err;
        row_irq[row_count]     = irq;
        row_wen[row_count]     = wen;
        row_wdata[row_count]   = wdata;
        row_cf[row_count]      = cf;
        row_target[row_count]  = target;
        row_kind[row_count]    = kind;
        row_cause[row_count]   = cause;
        row_next[row_count]    = next_pc;
        row_count++;
    endtask

    `include "tb_vectors.svh"

    task automatic check_value(string row, string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", row, what, exp, act);
        end
    endtask

    // Watchdog allows 20 cycles per row beyond reset
    initial begin
        #((16 + num_rows * 20) * 20);
        $display("Run stopped: the stage did not finish all rows in time");
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Table loop
    // ------------------------------------------------------------------------
    initial begin
        wb_instr_t   inst;
        logic [31:0] exp_pc;
        logic [31:0] trap_pc;
        logic [31:0] wr_data;
        logic [31:0] tgt;
        logic [5:0]  cause;
        logic [1:0]  kind;
        logic [4:0]  wr_rd;
        logic        wen_seen;
        logic        cf_seen;
        logic        give_rsp;
        logic        give_ack;
        logic        done;
        int          mem_delay;
        int          mem_wait;
        int          csr_cnt;
        int          mret_cnt;
        logic        is_mret;

        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        s4           = '0;
        s4_valid     = 1'b0;
        int_trap_req = 1'b0;
        csr_error    = 1'b0;
        cf_ack       = 1'b0;
        dmem         = '0;
        checks       = 0;
        errors       = 0;
        row_count    = 0;
        void'($urandom(32'h9e02));    // Seed once
        fill_table();
        exp_pc = 32'h8000_0000;

        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;

        for (int i = 0; i < num_rows; i++) begin
            inst       = '0;
            inst.rd    = row_rd[i];
            inst.opr_a = row_opr_a[i];
            inst.opr_b = row_opr_b[i];
            inst.uop   = row_uop[i];
            inst.fu    = row_fu[i];
            inst.size  = row_size[i];
            inst.instr = 32'h0000_1000 + i;
            is_mret    = row_fu[i][fu_cfu] && row_uop[i] == cfu_mret;
            mem_delay  = $urandom % 4;
            mem_wait   = 0;
            wen_seen   = 1'b0;
            cf_seen    = 1'b0;
            csr_cnt    = 0;
            mret_cnt   = 0;
            done       = 1'b0;

            @(posedge g_clk);
            s4           <= inst;
            s4_valid     <= 1'b1;
            int_trap_req <= row_irq[i];
            csr_error    <= row_csr_err[i];
            cf_ack       <= 1'b0;
            dmem         <= {1'b0, row_derr[i], row_rdata[i]};

            while (!done) begin
                @(negedge g_clk);
                give_rsp = 1'b0;
                give_ack = cf_req && !cf_ack;
                if (gpr.wen) begin
                    wen_seen = 1'b1;
                    wr_rd    = gpr.rd;
                    wr_data  = gpr.wdata;
                end
                if (!row_fu[i][fu_lsu]) begin
                    check_value(row_name[i], "dmem ack", 0, dmem_ack);
                end
                if (csr.en) begin
                    csr_cnt++;
                    check_value(row_name[i], "csr addr", row_opr_b[i][11:0], csr.addr);
                    check_value(row_name[i], "csr wdata", row_opr_a[i], csr.wdata);
                    check_value(row_name[i], "csr kind",
                                {row_uop[i][csr_write_bit], row_uop[i][csr_set_bit],
                                 row_uop[i][csr_clear_bit]},
                                {csr.wr, csr.set, csr.clr});
                end
                if (exec_mret) mret_cnt++;
                if (cf_req && !cf_seen) begin
                    cf_seen = 1'b1;
                    tgt     = cf_target;
                    kind    = {trap.cpu, trap.intr};
                    cause   = trap.cause;
                    trap_pc = trap.pc;
                end
                // Memory responder
                if (dmem_ack && !dmem.recv) begin
                    check_value(row_name[i], "busy before rsp", 1, s4_busy);
                    check_value(row_name[i], "lsu hold", 1, hold_lsu_req);
                    if (mem_wait == mem_delay) give_rsp = 1'b1;
                    else mem_wait++;
                end
                if (s4_valid && !s4_busy) begin
                    check_value(row_name[i], "trace valid", 1, trace.valid);
                    check_value(row_name[i], "trace pc", exp_pc, trace.pc);
                    check_value(row_name[i], "trace instr", inst.instr, trace.instr);
                    check_value(row_name[i], "lsu hold", row_cf[i], hold_lsu_req);
                    check_value(row_name[i], "fwd rd", row_rd[i], fwd.rd);
                    check_value(row_name[i], "fwd load", row_fu[i][fu_lsu], fwd.load);
                    check_value(row_name[i], "fwd csr", row_fu[i][fu_csr], fwd.csr);
                    if (row_wen[i]) begin
                        check_value(row_name[i], "fwd wdata", row_wdata[i], fwd.wdata);
                    end
                    done = 1'b1;
                end else begin
                    check_value(row_name[i], "trace idle", 0, trace.valid);
                    @(posedge g_clk);
                    dmem.recv <= give_rsp;
                    cf_ack    <= give_ack;
                end
            end

            check_value(row_name[i], "gpr wen", row_wen[i], wen_seen);
            if (row_wen[i] && wen_seen) begin
                check_value(row_name[i], "gpr rd", row_rd[i], wr_rd);
                check_value(row_name[i], "gpr wdata", row_wdata[i], wr_data);
            end
            check_value(row_name[i], "cf req", row_cf[i], cf_seen);
            if (row_cf[i] && cf_seen) begin
                check_value(row_name[i], "cf target", row_target[i], tgt);
                check_value(row_name[i], "trap kind", row_kind[i], kind);
                if (row_kind[i] != 2'b00) begin
                    check_value(row_name[i], "trap cause", row_cause[i], cause);
                    check_value(row_name[i], "trap pc", exp_pc, trap_pc);
                end
            end
            check_value(row_name[i], "csr accesses", row_fu[i][fu_csr], csr_cnt);
            check_value(row_name[i], "mret pulses", is_mret, mret_cnt);
            exp_pc = row_next[i];
        end

        @(posedge g_clk);
        s4_valid     <= 1'b0;
        s4           <= '0;
        int_trap_req <= 1'b0;
        cf_ack       <= 1'b0;
        dmem         <= '0;
        @(posedge g_clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* hw/frv_writeback.sv */
// --------------------------------------------------------------------------
// Writeback stage of the in-order core
// Holds one instruction at a time, fully combinational from s4
// Drive fu to zero while s4_valid is low
// pc_reset_value is passed to the PC tracker
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module frv_writeback import wb_pkg::*; #(
    parameter logic [31:0] pc_reset_value = 32'h8000_0000
) (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  wb_instr_t       s4,
    input  logic            s4_valid,
    output logic            s4_busy,
    output fwd_t            fwd,
    output gpr_wr_t         gpr,
    input  logic            int_trap_req,
    input  logic [5:0]      int_trap_cause,
    output trap_t           trap,
    output logic            exec_mret,
    input  logic [xlen-1:0] csr_mepc,
    input  logic [xlen-1:0] csr_mtvec,
    input  logic            vector_intrs,
    output trace_t          trace,
    output csr_req_t        csr,
    input  logic [xlen-1:0] csr_rdata,
    input  logic            csr_error,
    output logic            cf_req,
    output logic [xlen-1:0] cf_target,
    input  logic            cf_ack,
    output logic            hold_lsu_req,
    input  dmem_rsp_t       dmem,
    output logic            dmem_ack
);

    logic            progress;
    logic            cf_load;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    gpr_wr_t         load_wr;
    gpr_wr_t         csr_wr;
    gpr_wr_t         link_wr;
    logic            load_busy;
    logic            bus_error;
    logic            rsp_expected;
    logic            cfu_busy;
    logic            cf_done;
    logic            trap_int;

    // ------------------------------------------------------------------------
    // Stage control
    // ------------------------------------------------------------------------
    assign s4_busy  = cfu_busy || load_busy;
    assign progress = s4_valid && !s4_busy;
    assign cf_load  = cf_req && cf_ack;

    // No new LSU requests until this stage cannot trap
    assign hold_lsu_req = cf_req || load_busy || trap_int;

    assign trace.valid = |s4.size && (progress || (cf_load && !cf_done));
    assign trace.pc    = pc;
    assign trace.instr = s4.instr;

    // ------------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------------
    wb_pc_track #(.pc_reset_value(pc_reset_value)) i_pc_track (
        .g_clk(g_clk), .g_resetn(g_resetn), .size(s4.size), .progress(progress),
        .cf_load(cf_load), .cf_target(cf_target), .pc(pc), .pc_next(pc_next)
    );

    wb_load_unit i_load_unit (
        .g_clk(g_clk), .g_resetn(g_resetn), .s4(s4), .progress(progress),
        .dmem(dmem), .dmem_ack(dmem_ack), .wr(load_wr), .load_busy(load_busy),
        .bus_error(bus_error), .rsp_expected(rsp_expected)
    );

    wb_csr_unit i_csr_unit (
        .g_clk(g_clk), .g_resetn(g_resetn), .s4(s4), .progress(progress),
        .csr(csr), .csr_rdata(csr_rdata), .wr(csr_wr)
    );

    wb_cf_unit i_cf_unit (
        .g_clk(g_clk), .g_resetn(g_resetn), .s4(s4), .progress(progress),
        .pc(pc), .pc_next(pc_next), .csr_error(csr_error), .bus_error(bus_error),
        .rsp_expected(rsp_expected), .int_trap_req(int_trap_req),
        .int_trap_cause(int_trap_cause), .csr_mepc(csr_mepc), .csr_mtvec(csr_mtvec),
        .vector_intrs(vector_intrs), .cf_req(cf_req), .cf_target(cf_target),
        .cf_ack(cf_ack), .cf_done(cf_done), .cfu_busy(cfu_busy),
        .exec_mret(exec_mret), .trap(trap), .trap_int(trap_int), .wr(link_wr)
    );

    wb_gpr_arbiter i_gpr_arbiter (
        .s4(s4), .trap_int(trap_int), .load_wr(load_wr), .csr_wr(csr_wr),
        .link_wr(link_wr), .gpr(gpr), .fwd(fwd)
    );

endmodule

/* hw/wb_gpr_arbiter.sv */
// --------------------------------------------------------------------------
// Shared GPR write port and forwarding
// Exactly one fu bit is expected while an instruction is present
// A decode trap or an interrupt cancels the write
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module wb_gpr_arbiter import wb_pkg::*; (
    input  wb_instr_t s4,
    input  logic      trap_int,
    input  gpr_wr_t   load_wr,
    input  gpr_wr_t   csr_wr,
    input  gpr_wr_t   link_wr,
    output gpr_wr_t   gpr,
    output fwd_t      fwd
);

    gpr_wr_t exec_wr;    // ALU and MUL result, already final
    gpr_wr_t pick;

    assign exec_wr.wen   = s4.fu[fu_alu] || s4.fu[fu_mul];
    assign exec_wr.rd    = s4.rd;
    assign exec_wr.wdata = s4.opr_a;

    always_comb begin
        if (s4.fu[fu_lsu]) begin
            pick = load_wr;
        end else if (s4.fu[fu_csr]) begin
            pick = csr_wr;
        end else if (s4.fu[fu_cfu]) begin
            pick = link_wr;
        end else begin
            pick = exec_wr;
        end
    end

    assign gpr.wen   = pick.wen && !s4.trap && !trap_int;
    assign gpr.rd    = pick.rd;
    assign gpr.wdata = pick.wdata;

    assign fwd.rd    = gpr.rd;
    assign fwd.wdata = gpr.wdata;
    assign fwd.load  = s4.fu[fu_lsu] && s4.uop[lsu_load_bit];
    assign fwd.csr   = s4.fu[fu_csr];

endmodule

/* hw/wb_cf_unit.sv */
// --------------------------------------------------------------------------
// Control flow changes and traps
// Interrupts wait while a CPU trap or memory response is outstanding
// Vectored targets apply to interrupts only
// cf_req holds until cf_ack and is not raised again while stalled
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module wb_cf_unit import wb_pkg::*; (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  wb_instr_t       s4,
    input  logic            progress,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] pc_next,
    input  logic            csr_error,
    input  logic            bus_error,
    input  logic            rsp_expected,
    input  logic            int_trap_req,
    input  logic [5:0]      int_trap_cause,
    input  logic [xlen-1:0] csr_mepc,
    input  logic [xlen-1:0] csr_mtvec,
    input  logic            vector_intrs,
    output logic            cf_req,
    output logic [xlen-1:0] cf_target,
    input  logic            cf_ack,
    output logic            cf_done,
    output logic            cfu_busy,
    output logic            exec_mret,
    output trap_t           trap,
    output logic            trap_int,
    output gpr_wr_t         wr
);

    logic            is_cfu;
    logic            is_lsu;
    logic            taken;
    logic            link;
    logic            ebreak;
    logic            ecall;
    logic            mret;
    logic            csr_trap;
    logic            trap_cpu;
    logic            finish_now;
    logic            int_pending;
    logic [7:0]      vec_offset;
    logic [xlen-1:0] trap_target;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    assign is_cfu = s4.fu[fu_cfu];
    assign is_lsu = s4.fu[fu_lsu];
    assign link   = is_cfu && (s4.uop == cfu_jali || s4.uop == cfu_jalr);
    assign taken  = link || (is_cfu && s4.uop == cfu_taken);
    assign ebreak = is_cfu && s4.uop == cfu_ebreak;
    assign ecall  = is_cfu && s4.uop == cfu_ecall;
    assign mret   = is_cfu && s4.uop == cfu_mret;

    assign csr_trap = s4.fu[fu_csr] && csr_error;
    assign trap_cpu = ebreak || ecall || s4.trap || csr_trap || bus_error;

    // Interrupt only between memory responses and without a CPU trap
    assign trap_int = (int_trap_req || int_pending) && !trap_cpu && !rsp_expected;

    assign cf_req     = !cf_done && (taken || mret || trap_cpu || trap_int);
    assign finish_now = cf_req && cf_ack;

    assign cfu_busy  = cf_req && !cf_ack;    // Any change or trap waits for cf_ack
    assign exec_mret = mret && progress;    // Pulse to the CSR file

    // ------------------------------------------------------------------------
    // Target and cause
    // ------------------------------------------------------------------------
    assign vec_offset  = (vector_intrs && trap_int) ? {int_trap_cause, 2'b00} : 8'd0;
    assign trap_target = csr_mtvec + {24'b0, vec_offset};

    always_comb begin
        if (trap_cpu || trap_int) begin
            cf_target = trap_target;
        end else if (mret) begin
            cf_target = csr_mepc;
        end else if (taken) begin
            cf_target = s4.opr_a;    // Resolved by execute
        end else begin
            cf_target = '0;
        end
    end

    always_comb begin
        if (bus_error && is_lsu && s4.uop[lsu_load_bit]) begin
            trap.cause = trap_ldaccess;
        end else if (bus_error && is_lsu && s4.uop[lsu_store_bit]) begin
            trap.cause = trap_staccess;
        end else if (ebreak) begin
            trap.cause = trap_breakpt;
        end else if (ecall) begin
            trap.cause = trap_ecallm;
        end else if (csr_trap) begin
            trap.cause = trap_iopcode;
        end else if (trap_int) begin
            trap.cause = int_trap_cause;
        end else begin
            trap.cause = {1'b0, s4.rd};    // Decode puts its cause in rd
        end
    end

    assign trap.cpu  = trap_cpu;
    assign trap.intr = trap_int;
    assign trap.pc   = pc;

    // Link writes the return address
    assign wr.wen   = link;
    assign wr.rd    = s4.rd;
    assign wr.wdata = pc_next;

    // ------------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cf_done <= 1'b0;
        end else begin
            cf_done <= !progress && (cf_done || finish_now);
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            int_pending <= 1'b0;
        end else if (int_pending) begin
            int_pending <= !finish_now;    // Held until the trap is taken
        end else begin
            int_pending <= int_trap_req && !progress;
        end
    end

endmodule

/* hw/wb_csr_unit.sv */
// --------------------------------------------------------------------------
// CSR access for the writeback stage
// One access per instruction, in its first cycle only
// csr_rdata is taken in that same cycle
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module wb_csr_unit import wb_pkg::*; (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  wb_instr_t       s4,
    input  logic            progress,
    output csr_req_t        csr,
    input  logic [xlen-1:0] csr_rdata,
    output gpr_wr_t         wr
);

    logic is_csr;
    logic done;      // Access already made, stage stalled

    assign is_csr = s4.fu[fu_csr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done <= 1'b0;
        end else begin
            done <= !progress && (done || csr.en);
        end
    end

    assign csr.en    = is_csr && !done;
    assign csr.wr    = is_csr && s4.uop[csr_write_bit];
    assign csr.set   = is_csr && s4.uop[csr_set_bit];
    assign csr.clr   = is_csr && s4.uop[csr_clear_bit];
    assign csr.addr  = s4.opr_b[11:0];
    assign csr.wdata = s4.opr_a;

    assign wr.wen   = csr.en && s4.uop[csr_read_bit];    // Read kinds only
    assign wr.rd    = s4.rd;
    assign wr.wdata = csr_rdata;

endmodule

/* hw/wb_load_unit.sv */
// --------------------------------------------------------------------------
// Data memory response handling for loads and stores
// Takes exactly one response per instruction
// Strobes in opr_a[3:0] must match the access size and address
// Word loads assume a word aligned address
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module wb_load_unit import wb_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  wb_instr_t s4,
    input  logic      progress,
    input  dmem_rsp_t dmem,
    output logic      dmem_ack,
    output gpr_wr_t   wr,
    output logic      load_busy,
    output logic      bus_error,
    output logic      rsp_expected
);

    logic            is_lsu;
    logic            is_load;
    logic            is_byte;
    logic            is_word;
    logic            is_signed;
    logic [3:0]      strb;
    logic [1:0]      offset;
    logic            rsp_take;
    logic            rsp_seen;
    logic            error_seen;
    logic            n_error_seen;
    logic [xlen-1:0] masked;
    logic [xlen-1:0] shifted;
    logic [7:0]      rdata_b0;
    logic [7:0]      rdata_b1;
    logic [15:0]     rdata_h1;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    assign is_lsu    = s4.fu[fu_lsu];
    assign is_load   = is_lsu && s4.uop[lsu_load_bit];
    assign is_byte   = s4.uop[2:1] == lsu_byte;
    assign is_word   = s4.uop[2:1] == lsu_word;    // Half is neither
    assign is_signed = s4.uop[lsu_signed_bit];
    assign strb      = s4.opr_a[3:0];             // Lanes from memory stage
    assign offset    = s4.opr_b[1:0];             // Byte address within word

    // ------------------------------------------------------------------------
    // Response tracking
    // ------------------------------------------------------------------------
    assign rsp_expected = is_lsu && !rsp_seen;
    assign dmem_ack     = rsp_expected;
    assign rsp_take     = dmem.recv && dmem_ack;

    // Still waiting unless the response arrives now
    assign load_busy = is_lsu && !(rsp_seen || rsp_take);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen <= 1'b0;
        end else begin
            rsp_seen <= !progress && (rsp_seen || rsp_take);
        end
    end

    // Error sticks until the instruction leaves
    assign n_error_seen = error_seen || (rsp_take && dmem.error);
    assign bus_error    = n_error_seen;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            error_seen <= 1'b0;
        end else if (progress) begin
            error_seen <= 1'b0;
        end else begin
            error_seen <= n_error_seen;
        end
    end

    // ------------------------------------------------------------------------
    // Alignment and extension
    // ------------------------------------------------------------------------
    assign masked = dmem.rdata & {{8{strb[3]}}, {8{strb[2]}},
                                  {8{strb[1]}}, {8{strb[0]}}};
    assign shifted = masked >> {offset, 3'b000};    // Addressed lane to bit 0

    assign rdata_b0 = shifted[7:0];
    assign rdata_b1 = is_byte ? {8{is_signed && rdata_b0[7]}} : shifted[15:8];
    assign rdata_h1 = is_word ? shifted[31:16] : {16{is_signed && rdata_b1[7]}};

    // Write only on a clean load response
    assign wr.wen   = is_load && rsp_take && !dmem.error;
    assign wr.rd    = s4.rd;
    assign wr.wdata = {rdata_h1, rdata_b1, rdata_b0};

endmodule

/* hw/wb_pc_track.sv */
// --------------------------------------------------------------------------
// Writeback program counter
// A completed control flow change wins over sequential advance
// Size counts halfwords, so the step is 0, 2, 4 or 6 bytes
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module wb_pc_track import wb_pkg::*; #(
    parameter logic [31:0] pc_reset_value = 32'h8000_0000
) (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic [1:0]      size,
    input  logic            progress,
    input  logic            cf_load,      // cf_req and cf_ack together
    input  logic [xlen-1:0] cf_target,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pc_next
);

    assign pc_next = pc + {29'b0, size, 1'b0};    // Bytes = 2 * halfwords

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= pc_reset_value;
        end else if (cf_load) begin
            pc <= cf_target;
        end else if (progress) begin
            pc <= pc_next;
        end
    end

endmodule

/* hw/wb_pkg.sv */
// --------------------------------------------------------------------------
// Shared widths, codes and packed records of the writeback stage
// XLEN is fixed at 32 because load alignment assumes four byte lanes
// The fu field is one-hot over five units
// Micro-op codes are five bits and are read per unit
// --------------------------------------------------------------------------
package wb_pkg;

    localparam int xlen = 32;

    // Bit positions in the one-hot unit field
    localparam int fu_alu = 0;
    localparam int fu_mul = 1;
    localparam int fu_lsu = 2;
    localparam int fu_cfu = 3;
    localparam int fu_csr = 4;

    // ------------------------------------------------------------------------
    // Micro-op codes
    // ------------------------------------------------------------------------
    localparam logic [4:0] cfu_taken  = 5'd1;    // Conditional branch taken
    localparam logic [4:0] cfu_jali   = 5'd2;    // JAL
    localparam logic [4:0] cfu_jalr   = 5'd3;    // JALR
    localparam logic [4:0] cfu_ebreak = 5'd4;
    localparam logic [4:0] cfu_ecall  = 5'd5;
    localparam logic [4:0] cfu_mret   = 5'd6;

    localparam int lsu_signed_bit = 0;
    localparam int lsu_load_bit   = 3;
    localparam int lsu_store_bit  = 4;
    localparam logic [1:0] lsu_byte = 2'b01;     // Size codes in uop[2:1]
    localparam logic [1:0] lsu_half = 2'b10;
    localparam logic [1:0] lsu_word = 2'b11;

    localparam int csr_clear_bit = 1;
    localparam int csr_set_bit   = 2;
    localparam int csr_write_bit = 3;
    localparam int csr_read_bit  = 4;

    // Trap causes
    localparam logic [5:0] trap_iopcode  = 6'd2;
    localparam logic [5:0] trap_breakpt  = 6'd3;
    localparam logic [5:0] trap_ldaccess = 6'd5;
    localparam logic [5:0] trap_staccess = 6'd7;
    localparam logic [5:0] trap_ecallm   = 6'd11;

    // ------------------------------------------------------------------------
    // Records
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [4:0]      rd;
        logic [xlen-1:0] opr_a;
        logic [xlen-1:0] opr_b;
        logic [4:0]      uop;
        logic [4:0]      fu;       // One-hot unit select
        logic            trap;     // Decode raised a trap
        logic [1:0]      size;     // In halfwords
        logic [31:0]     instr;
    } wb_instr_t;

    typedef struct packed {
        logic            wen;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
    } gpr_wr_t;

    typedef struct packed {
        logic            en;
        logic            wr;
        logic            set;
        logic            clr;
        logic [11:0]     addr;
        logic [xlen-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic            recv;
        logic            error;
        logic [xlen-1:0] rdata;
    } dmem_rsp_t;

    typedef struct packed {
        logic            cpu;
        logic            intr;
        logic [5:0]      cause;
        logic [xlen-1:0] pc;
    } trap_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
    } trace_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
        logic            load;      // Load in writeback
        logic            csr;       // CSR access in writeback
    } fwd_t;

endpackage
